// ==== Bender.yml ====
package:
  name: iwm_ctrl

sources:
  # RTL in compile order
  - files:
      - verilog/iwm_pkg.sv
      - verilog/iwm_switch_if.sv
      - verilog/iwm_soft_switch.sv
      - verilog/iwm_motor_inertia.sv
      - verilog/iwm_status_read.sv
      - verilog/iwm_ctrl.sv

  # Testbench
  - target: simulation
    files:
      - test/tb_iwm_ctrl.sv

// ==== project.f ====
verilog/iwm_pkg.sv
verilog/iwm_switch_if.sv
verilog/iwm_soft_switch.sv
verilog/iwm_motor_inertia.sv
verilog/iwm_status_read.sv
verilog/iwm_ctrl.sv
test/tb_iwm_ctrl.sv

// ==== test/tb_iwm_ctrl.sv ====
// IWM controller testbench with stimulus table, switch reference model and motor inertia checks
`timescale 1ns/100ps
`default_nettype none

module tb_iwm_ctrl;

    // One bus access with its drive conditions and expected responses
    typedef struct packed {
        logic       is_write;
        logic       ph2;
        logic [3:0] hold;    // cycles with DEVICE_SELECT high
        logic [3:0] addr;
        logic [7:0] data;
        logic [7:0] disk35;
        logic [2:0] sense;   // {SENSE_35_2, SENSE_35_1, SENSE_525}
        logic [3:0] ready;
        logic       chk;
        logic [7:0] dout;    // D_OUT during the access
        logic [3:0] phases;  // PHASES after the access
        logic [2:0] sidx;    // SENSE_REG during the access
    } row_t;

    logic       CLK_14M;
    logic       RESET;
    logic       ph2;
    logic       device_select;
    logic       wr_cycle;
    logic [3:0] a;
    logic [7:0] d_in;
    logic [7:0] disk35;
    logic [3:0] disk_ready;
    logic       sense_525;
    logic       sense_35_1;
    logic       sense_35_2;
    logic [7:0] d_out;
    logic [3:0] phases;
    logic [2:0] sense_reg;
    logic       motor_on;
    logic [31:0] rnd;
    row_t        rows[$];

    // Reference model state
    logic [3:0] m_phases;
    logic       m_drive_on;
    logic       m_drive_sel;
    logic       m_q6;
    logic       m_q7;
    logic [4:0] m_mode;
    logic [2:0] m_sidx;

    // Short inertia times keep the motor checks quick
    iwm_ctrl #(
        .SPINUP_CYCLES   (20),
        .SPINDOWN_CYCLES (40)
    ) dut_i (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .PH2             (ph2),
        .DEVICE_SELECT   (device_select),
        .WR_CYCLE        (wr_cycle),
        .A               (a),
        .D_IN            (d_in),
        .D_OUT           (d_out),
        .DISK35          (disk35),
        .DISK_READY      (disk_ready),
        .SENSE_525       (sense_525),
        .SENSE_35_1      (sense_35_1),
        .SENSE_35_2      (sense_35_2),
        .PHASES          (phases),
        .SENSE_REG       (sense_reg),
        .FLOPPY_MOTOR_ON (motor_on)
    );

    // 10 ns clock
    initial begin
        CLK_14M = 1'b0;
        forever #5 CLK_14M = ~CLK_14M;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_signal(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Error at time %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic row_t make_row(input logic is_write, input logic ph2_lvl,
                                      input logic [3:0] hold, input logic [3:0] addr,
                                      input logic [7:0] data, input logic [7:0] d35,
                                      input logic [2:0] sense, input logic [3:0] ready,
                                      input logic chk, input logic [7:0] dout,
                                      input logic [3:0] ph, input logic [2:0] sidx);
        row_t r;
        r = '{is_write, ph2_lvl, hold, addr, data, d35, sense, ready, chk, dout, ph, sidx};
        return r;
    endfunction

    // ==================================================
    // Reference model
    // ==================================================

    // Applies one access to the model state and returns what the bus shows during it
    task automatic model_access(input row_t r, output logic [7:0] dout, output logic [2:0] sidx);
        logic [2:0] sel;
        logic       a0;
        logic [3:0] ph_next;
        logic       imm_q6;
        logic       imm_q7;
        logic       imm_motor;
        logic       mode_wr;
        logic       sense;
        sel = r.addr[3:1];
        a0 = r.addr[0];
        ph_next = m_phases;
        if (!r.addr[3]) begin
            ph_next[r.addr[2:1]] = a0;
        end
        imm_q6 = (sel == 3'd6) ? a0 : m_q6;
        imm_q7 = (sel == 3'd7) ? a0 : m_q7;
        mode_wr = r.is_write && !m_drive_on && imm_q6 && imm_q7 && a0;
        // Registers only move when PH2 is high at the clock edge
        if (r.ph2) begin
            case (sel)
                3'd0, 3'd1, 3'd2, 3'd3: begin
                    m_phases = ph_next;
                    m_sidx = ph_next[2:0];
                end
                3'd4: m_drive_on = a0;
                3'd5: m_drive_sel = a0;
                3'd6: m_q6 = a0;
                default: m_q7 = a0;
            endcase
            if (mode_wr) begin
                m_mode = r.data[4:0];
            end
        end
        // Sampled after the update edge, so the new motor state applies
        mode_wr = r.is_write && !m_drive_on && imm_q6 && imm_q7 && a0;
        imm_motor = (sel == 3'd4) ? a0 : m_drive_on;
        if (!m_drive_on) begin
            sense = 1'b1;
        end else if (r.disk35[6]) begin
            sense = m_drive_sel ? r.sense[2] : r.sense[1];
        end else begin
            sense = m_drive_sel ? 1'b1 : r.sense[0];
        end
        if (imm_q6 && !imm_q7) begin
            dout = {sense, 1'b0, imm_motor, mode_wr ? r.data[4:0] : m_mode};
        end else begin
            dout = 8'hFF;
        end
        sidx = !r.addr[3] ? ph_next[2:0] : m_sidx;
    endtask

    // ==================================================
    // Bus access
    // ==================================================

    task automatic run_access(input row_t r, input logic from_table);
        logic [7:0] exp_dout;
        logic [2:0] exp_sidx;
        model_access(r, exp_dout, exp_sidx);
        // Hand-written columns must agree with the model
        if (from_table) begin
            if (r.chk) begin
                check_signal("table D_OUT", r.dout, exp_dout);
            end
            check_signal("table PHASES", r.phases, m_phases);
            check_signal("table SENSE_REG", r.sidx, exp_sidx);
        end
        @(negedge CLK_14M);
        disk35 = r.disk35;
        disk_ready = r.ready;
        {sense_35_2, sense_35_1, sense_525} = r.sense;
        ph2 = r.ph2;
        wr_cycle = !r.is_write;
        a = r.addr;
        rnd = $urandom;
        d_in = r.is_write ? r.data : rnd[7:0];
        device_select = 1'b1;
        // One update edge has passed, read data is stable here
        @(negedge CLK_14M);
        if (!from_table || r.chk) begin
            check_signal("D_OUT", d_out, exp_dout);
        end
        check_signal("SENSE_REG", {5'd0, sense_reg}, {5'd0, exp_sidx});
        repeat (r.hold - 1) @(negedge CLK_14M);
        device_select = 1'b0;
        ph2 = 1'b1;
        @(negedge CLK_14M);
        check_signal("PHASES", {4'd0, phases}, {4'd0, m_phases});
        check_signal("SENSE_REG", {5'd0, sense_reg}, {5'd0, m_sidx});
    endtask

    // Waits for FLOPPY_MOTOR_ON to reach a level inside a cycle window
    task automatic wait_motor(input logic level, input int min_cyc, input int max_cyc);
        int n;
        n = 0;
        while (motor_on !== level) begin
            @(negedge CLK_14M);
            n++;
            assert (n <= max_cyc) else begin
                $display("Timeout: FLOPPY_MOTOR_ON did not reach %b within %0d cycles",
                         level, max_cyc);
                abort_run();
            end
        end
        assert (n >= min_cyc) else begin
            $display("Error at time %0t: FLOPPY_MOTOR_ON reached %b after %0d cycles expected %0d",
                     $time, level, n, min_cyc);
            abort_run();
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        rnd = $urandom(32'h5952);
        RESET = 1'b1;
        ph2 = 1'b1;
        device_select = 1'b0;
        wr_cycle = 1'b1;
        a = 4'h0;
        d_in = 8'h00;
        disk35 = 8'h00;
        disk_ready = 4'h0;
        sense_525 = 1'b0;
        sense_35_1 = 1'b0;
        sense_35_2 = 1'b0;
        {m_phases, m_drive_on, m_drive_sel, m_q6, m_q7, m_mode, m_sidx} = '0;

        // wr, ph2, hold, addr, data, disk35, sense, ready, chk, dout, phases, sidx
        // Phases and latched sense index
        rows.push_back(make_row(0, 1, 2, 4'h1, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'h1, 3'b001));
        rows.push_back(make_row(0, 1, 2, 4'h5, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'h5, 3'b101));
        rows.push_back(make_row(0, 1, 2, 4'h7, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hD, 3'b101));
        rows.push_back(make_row(0, 1, 2, 4'h0, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hD, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h80, 4'hC, 3'b100));
        // Immediate motor bit on and off
        rows.push_back(make_row(0, 1, 2, 4'h9, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h20, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'h8, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h80, 4'hC, 3'b100));
        // Mode write with motor off, then blocked with motor on
        rows.push_back(make_row(0, 1, 2, 4'hE, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h80, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hD, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h80, 4'hC, 3'b100));
        rows.push_back(make_row(1, 1, 2, 4'hF, 8'hF3, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hE, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'h9, 8'h00, 8'h00, 3'b001, 4'h0, 1, 8'hB3, 4'hC, 3'b100));
        rows.push_back(make_row(1, 1, 2, 4'hF, 8'h05, 8'h00, 3'b001, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hE, 8'h00, 8'h00, 3'b001, 4'h0, 1, 8'hB3, 4'hC, 3'b100));
        // Sense table for both drive types
        rows.push_back(make_row(0, 1, 2, 4'hD, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h33, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hB, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hB3, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hB, 8'h00, 8'h40, 3'b010, 4'h0, 1, 8'h33, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hB, 8'h00, 8'h40, 3'b100, 4'h0, 1, 8'hB3, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hA, 8'h00, 8'h40, 3'b100, 4'h0, 1, 8'h33, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hA, 8'h00, 8'h40, 3'b010, 4'h0, 1, 8'hB3, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'h8, 8'h00, 8'h40, 3'b000, 4'h0, 1, 8'h93, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'h8, 8'h00, 8'h00, 3'b111, 4'h0, 1, 8'h93, 4'hC, 3'b100));
        // Non-status reads
        rows.push_back(make_row(0, 1, 2, 4'hC, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hA, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hD, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hF, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'hFF, 4'hC, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'hE, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hC, 3'b100));
        // Long select, PH2 low, then a normal access
        rows.push_back(make_row(1, 1, 10, 4'h3, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hE, 3'b110));
        rows.push_back(make_row(0, 0, 2, 4'h2, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hE, 3'b100));
        rows.push_back(make_row(0, 1, 2, 4'h2, 8'h00, 8'h00, 3'b000, 4'h0, 1, 8'h93, 4'hC, 3'b100));

        repeat (8) @(posedge CLK_14M);
        @(negedge CLK_14M);
        RESET = 1'b0;

        foreach (rows[i]) begin
            run_access(rows[i], 1'b1);
        end

        // ==================================================
        // Motor inertia
        // ==================================================

        // 3.5" drives never spin the 5.25" spindle
        run_access(make_row(0, 1, 2, 4'h9, 8'h00, 8'h40, 3'b000, 4'h1, 1, 8'h00, 4'h0, 3'b0), 1'b0);
        for (int i = 0; i < 60; i++) begin
            @(negedge CLK_14M);
            assert (motor_on === 1'b0) else begin
                $display("Error at time %0t: FLOPPY_MOTOR_ON got %b expected 0 in 3.5-inch mode",
                         $time, motor_on);
                abort_run();
            end
        end
        run_access(make_row(0, 1, 2, 4'h8, 8'h00, 8'h40, 3'b000, 4'h1, 1, 8'h00, 4'h0, 3'b0), 1'b0);

        // 5.25" spin-up, then spin-down
        run_access(make_row(0, 1, 2, 4'h9, 8'h00, 8'h00, 3'b000, 4'h1, 1, 8'h00, 4'h0, 3'b0), 1'b0);
        wait_motor(1'b1, 10, 30);
        run_access(make_row(0, 1, 2, 4'h8, 8'h00, 8'h00, 3'b000, 4'h1, 1, 8'h00, 4'h0, 3'b0), 1'b0);
        wait_motor(1'b0, 20, 50);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/iwm_ctrl.sv ====
// IWM controller top: soft switches, 5.25" motor inertia and status read path
`timescale 1ns/100ps
`default_nettype none

module iwm_ctrl #(
    parameter int unsigned SPINUP_CYCLES   = iwm_pkg::SPINUP_CYCLES_DEF,
    parameter int unsigned SPINDOWN_CYCLES = iwm_pkg::SPINDOWN_CYCLES_DEF
) (
    input  logic                        CLK_14M,
    input  logic                        RESET,

    // CPU bus
    input  logic                        PH2,
    input  logic                        DEVICE_SELECT,
    // 0 = write, 1 = read
    input  logic                        WR_CYCLE,
    input  logic [iwm_pkg::ADDR_W-1:0]  A,
    input  logic [iwm_pkg::DATA_W-1:0]  D_IN,
    output logic [iwm_pkg::DATA_W-1:0]  D_OUT,

    // System registers
    input  logic [7:0]                  DISK35,
    input  logic [3:0]                  DISK_READY,

    // Drive sense lines
    input  logic                        SENSE_525,
    input  logic                        SENSE_35_1,
    input  logic                        SENSE_35_2,

    // To the external drive models
    output iwm_pkg::phase_t             PHASES,
    output iwm_pkg::sense_idx_t         SENSE_REG,
    output logic                        FLOPPY_MOTOR_ON
);

    logic is_35;
    logic spinning;

    // DISK35 picks 3.5" versus 5.25" drives
    assign is_35 = DISK35[iwm_pkg::DISK35_IS35_BIT];

    // ==================================================
    // Soft switches
    // ==================================================

    iwm_switch_if sw_if ();

    iwm_soft_switch soft_switch_i (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .dev_select (DEVICE_SELECT),
        .wr_cycle   (WR_CYCLE),
        .ph2        (PH2),
        .a          (A),
        .d_in       (D_IN),
        .sw         (sw_if.owner)
    );

    // ==================================================
    // Motor inertia and read path
    // ==================================================

    iwm_motor_inertia #(
        .SPINUP_CYCLES   (SPINUP_CYCLES),
        .SPINDOWN_CYCLES (SPINDOWN_CYCLES)
    ) motor_inertia_i (
        .CLK_14M  (CLK_14M),
        .RESET    (RESET),
        .drive_on (sw_if.drive_on),
        .is_35    (is_35),
        .spinning (spinning)
    );

    iwm_status_read status_read_i (
        .sw         (sw_if.reader),
        .is_35      (is_35),
        .sense_525  (SENSE_525),
        .sense_35_1 (SENSE_35_1),
        .sense_35_2 (SENSE_35_2),
        .d_out      (D_OUT)
    );

    // Drive models step on registered phases, sense uses the live index
    assign PHASES    = sw_if.phases;
    assign SENSE_REG = sw_if.sense_idx;

    // Only the first 5.25" drive with a mounted image slows the clock
    assign FLOPPY_MOTOR_ON = spinning && DISK_READY[0];

endmodule

`default_nettype wire

// ==== verilog/iwm_motor_inertia.sv ====
// 5.25" spindle model with spin-up delay and spin-down hold counter
`timescale 1ns/100ps
`default_nettype none

module iwm_motor_inertia #(
    parameter int unsigned SPINUP_CYCLES   = iwm_pkg::SPINUP_CYCLES_DEF,
    parameter int unsigned SPINDOWN_CYCLES = iwm_pkg::SPINDOWN_CYCLES_DEF
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic drive_on,
    input  logic is_35,
    output logic spinning
);

    localparam int W = iwm_pkg::MOTOR_CNT_W;

    // Counter-width copies of the timing parameters
    localparam logic [W-1:0] SPINUP_CNT   = W'(SPINUP_CYCLES);
    localparam logic [W-1:0] SPINDOWN_CNT = W'(SPINDOWN_CYCLES);

    logic [W-1:0] count;

    // ==================================================
    // Inertia counter
    // ==================================================

    // Counts up during spin-up, holds at the spin-down value
    // while spinning, then counts down after motor-off
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            spinning <= 1'b0;
            count    <= '0;
        end else if (is_35) begin
            // 3.5" drives handle their own motor
            spinning <= 1'b0;
            count    <= '0;
        end else if (drive_on) begin
            if (spinning) begin
                // Keep the full spin-down time ready
                count <= SPINDOWN_CNT;
            end else if (count >= SPINUP_CNT) begin
                spinning <= 1'b1;
                count    <= SPINDOWN_CNT;
            end else begin
                count <= count + 1'b1;
            end
        end else begin
            // Platter coasts until the hold time runs out
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                spinning <= 1'b0;
            end
        end
    end

    // ==================================================
    // Assertions
    // ==================================================

    // Motor-off countdown always starts at or below the hold time
    a_spindown_bound : assert property (
        @(posedge CLK_14M) disable iff (RESET)
        !drive_on |-> (count <= SPINDOWN_CNT)
    );

endmodule

`default_nettype wire

// ==== verilog/iwm_pkg.sv ====
// IWM soft-switch package: switch selector codes, bus widths, inertia timing and status layout
`default_nettype none

package iwm_pkg;

    // ==================================================
    // Bus widths
    // ==================================================

    // Only A[3:0] reaches the IWM, the upper bits decode the slot
    localparam int ADDR_W = 4;
    localparam int DATA_W = 8;

    // ==================================================
    // Soft switch selector
    // ==================================================

    // Address bits 3..1 pick the switch, A[0] carries the new value
    typedef enum logic [2:0] {
        SW_PH0       = 3'd0,
        SW_PH1       = 3'd1,
        SW_PH2       = 3'd2,
        SW_PH3       = 3'd3,
        SW_MOTOR     = 3'd4,
        SW_DRIVE_SEL = 3'd5,
        SW_Q6        = 3'd6,
        SW_Q7        = 3'd7
    } sw_sel_t;

    // Stepper phase lines PH0..PH3
    typedef logic [3:0] phase_t;

    // Mode register, byte bits 7..5 read back as zero
    typedef logic [4:0] mode_t;

    // Sense register index, the low three phases at the last phase access
    typedef logic [2:0] sense_idx_t;

    // ==================================================
    // Motor inertia (14 MHz cycles)
    // ==================================================

    localparam int MOTOR_CNT_W = 24;
    // About 300 ms of spin-up
    localparam int unsigned SPINUP_CYCLES_DEF   = 4_200_000;
    // About one second of spin-down
    localparam int unsigned SPINDOWN_CYCLES_DEF = 14_000_000;

    // ==================================================
    // DISK35 register and status byte layout
    // ==================================================

    localparam int DISK35_IS35_BIT  = 6;
    localparam int STATUS_SENSE_BIT = 7;
    localparam int STATUS_MOTOR_BIT = 5;

    // Data and handshake registers are not modelled
    localparam logic [DATA_W-1:0] READ_IDLE_BYTE = 8'hFF;

endpackage

`default_nettype wire

// ==== verilog/iwm_soft_switch.sv ====
// IWM soft switches: access edge detect, switch and mode registers, immediate view, sense latch
`timescale 1ns/100ps
`default_nettype none

module iwm_soft_switch (
    input  logic                        CLK_14M,
    input  logic                        RESET,
    input  logic                        dev_select,
    input  logic                        wr_cycle,
    input  logic                        ph2,
    input  logic [iwm_pkg::ADDR_W-1:0]  a,
    input  logic [iwm_pkg::DATA_W-1:0]  d_in,
    iwm_switch_if.owner                 sw
);

    // ==================================================
    // Address decode
    // ==================================================

    iwm_pkg::sw_sel_t    sel;
    logic                access_latched;
    logic                access_edge;
    logic                phase_access;
    logic                mode_write;
    iwm_pkg::phase_t     phases_next;
    iwm_pkg::mode_t      mode_reg;
    iwm_pkg::sense_idx_t sense_reg;

    assign sel = iwm_pkg::sw_sel_t'(a[3:1]);

    // One update per bus access, the latch blocks the rest of the cycle
    assign access_edge = dev_select && ph2 && !access_latched;

    // Phase switches occupy the lower half of the map
    assign phase_access = dev_select && !a[3];

    // Phase vector as it will look once this access lands
    always_comb begin
        phases_next = sw.phases;
        if (!a[3]) begin
            phases_next[a[2:1]] = a[0];
        end
    end

    // ==================================================
    // Immediate view
    // ==================================================

    // New switch value is visible the moment the address is on the bus
    assign sw.immediate_motor = (dev_select && sel == iwm_pkg::SW_MOTOR) ? a[0] : sw.drive_on;
    assign sw.immediate_q6    = (dev_select && sel == iwm_pkg::SW_Q6)    ? a[0] : sw.q6;
    assign sw.immediate_q7    = (dev_select && sel == iwm_pkg::SW_Q7)    ? a[0] : sw.q7;

    // Mode write: CPU write, motor off, Q6 and Q7 set, odd address
    assign mode_write = dev_select && !wr_cycle && !sw.drive_on
                     && sw.immediate_q6 && sw.immediate_q7 && a[0];

    // Status reads right after the write must see the new mode
    assign sw.immediate_mode = mode_write ? d_in[4:0] : mode_reg;

    // Drive models read the new index during the phase access itself
    assign sw.sense_idx = phase_access ? phases_next[2:0] : sense_reg;

    // ==================================================
    // Switch registers
    // ==================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            sw.phases      <= '0;
            sw.drive_on    <= 1'b0;
            sw.drive_sel   <= 1'b0;
            sw.q6          <= 1'b0;
            sw.q7          <= 1'b0;
            mode_reg       <= '0;
            sense_reg      <= '0;
            access_latched <= 1'b0;
        end else begin
            // Re-arm once the CPU releases the device select
            if (!dev_select) begin
                access_latched <= 1'b0;
            end

            if (access_edge) begin
                access_latched <= 1'b1;

                // Every access, read or write, latches A[0] into its switch
                case (sel)
                    iwm_pkg::SW_PH0,
                    iwm_pkg::SW_PH1,
                    iwm_pkg::SW_PH2,
                    iwm_pkg::SW_PH3: begin
                        sw.phases <= phases_next;
                        // Set and clear both refresh the sense index
                        sense_reg <= phases_next[2:0];
                    end
                    iwm_pkg::SW_MOTOR:     sw.drive_on  <= a[0];
                    iwm_pkg::SW_DRIVE_SEL: sw.drive_sel <= a[0];
                    iwm_pkg::SW_Q6:        sw.q6        <= a[0];
                    iwm_pkg::SW_Q7:        sw.q7        <= a[0];
                    default: ;
                endcase

                // Q6/Q7 are taken in their immediate form here
                if (mode_write) begin
                    mode_reg <= d_in[4:0];
                end
            end
        end
    end

    // ==================================================
    // Assertions
    // ==================================================

    // Mode is frozen while the motor command is on
    a_mode_stable_motor_on : assert property (
        @(posedge CLK_14M) disable iff (RESET)
        $changed(mode_reg) |-> !$past(sw.drive_on)
    );

    // Latch only sets from a selected bus cycle
    a_latch_needs_select : assert property (
        @(posedge CLK_14M) disable iff (RESET)
        $rose(access_latched) |-> $past(dev_select)
    );

endmodule

`default_nettype wire

// ==== verilog/iwm_status_read.sv ====
// IWM read path: drive sense selection and status byte assembly
`timescale 1ns/100ps
`default_nettype none

module iwm_status_read (
    iwm_switch_if.reader                sw,
    input  logic                        is_35,
    input  logic                        sense_525,
    input  logic                        sense_35_1,
    input  logic                        sense_35_2,
    output logic [iwm_pkg::DATA_W-1:0]  d_out
);

    logic                       drive_sense;
    logic                       sense;
    logic                       status_sel;
    logic [iwm_pkg::DATA_W-1:0] status_byte;

    // ==================================================
    // Sense selection
    // ==================================================

    // Second 5.25" drive is absent and always reads back as 1
    always_comb begin
        if (is_35) begin
            drive_sense = sw.drive_sel ? sense_35_2 : sense_35_1;
        end else begin
            drive_sense = sw.drive_sel ? 1'b1 : sense_525;
        end
    end

    // No drive is connected while the motor command is off
    assign sense = sw.drive_on ? drive_sense : 1'b1;

    // ==================================================
    // Status byte
    // ==================================================

    // Q6=1, Q7=0 addresses the status register
    assign status_sel = sw.immediate_q6 && !sw.immediate_q7;

    always_comb begin
        status_byte = '0;
        status_byte[$bits(iwm_pkg::mode_t)-1:0] = sw.immediate_mode;
        // Motor bit follows the command, not the spindle
        status_byte[iwm_pkg::STATUS_MOTOR_BIT]  = sw.immediate_motor;
        status_byte[iwm_pkg::STATUS_SENSE_BIT]  = sense;
    end

    // Data and handshake registers read as idle
    assign d_out = status_sel ? status_byte : iwm_pkg::READ_IDLE_BYTE;

    // ==================================================
    // Assertions
    // ==================================================

    // Bit 6 is reserved in the status layout
    always_comb begin
        if (status_sel) begin
            a_status_bit6_zero : assert final (d_out[6] == 1'b0);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/iwm_switch_if.sv ====
// Soft-switch state interface: registered switches, immediate bus view and sense index
`timescale 1ns/100ps
`default_nettype none

interface iwm_switch_if;

    // ==================================================
    // Registered switch state
    // ==================================================

    // Stepper phases as latched at the last update edge
    iwm_pkg::phase_t phases;
    // Motor command
    logic            drive_on;
    // 0 = first drive, 1 = second drive
    logic            drive_sel;
    // Q6/Q7 register select bits
    logic            q6;
    logic            q7;

    // ==================================================
    // Immediate view of the current bus cycle
    // ==================================================

    // These already hold A[0] while the CPU addresses the matching switch
    logic            immediate_motor;
    logic            immediate_q6;
    logic            immediate_q7;
    // New mode value during a mode write, stored value otherwise
    iwm_pkg::mode_t  immediate_mode;

    // Sense index, shows the new phases during a phase access
    iwm_pkg::sense_idx_t sense_idx;

    // Soft switch block drives everything
    modport owner (
        output phases,
        output drive_on,
        output drive_sel,
        output q6,
        output q7,
        output immediate_motor,
        output immediate_q6,
        output immediate_q7,
        output immediate_mode,
        output sense_idx
    );

    // Read path only needs what shapes the status byte
    modport reader (
        input drive_on,
        input drive_sel,
        input immediate_motor,
        input immediate_q6,
        input immediate_q7,
        input immediate_mode
    );

endinterface

`default_nettype wire
